//--- Makefile
# Verilator build and run for the external memory controller testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = memory_controller_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_TEXT = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator's exit status is not trusted, the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
src/memctl_pkg.sv
src/cpu_bus_port.sv
src/instr_cache.sv
src/byte_sram_sequencer.sv
src/memory_controller.sv
testbench/clock_gen.sv
testbench/sram_model.sv
testbench/memory_controller_tb.sv

//--- src/byte_sram_sequencer.sv
/* Byte SRAM sequencer
   Runs one 16-bit access as two four-clock byte cycles on a byte-wide SRAM,
   low byte first, and drives the SRAM pins */

`timescale 1ns/1ps
`default_nettype none

module byte_sram_sequencer (
   input  wire                  clock,
   input  wire                  reset_b,
   input  wire memctl_pkg::cpu_req_t req,
   input  wire                  hit,
   output logic                 busy,
   output logic                 access_end,
   output logic [15:0]          rdata,
   output memctl_pkg::ram_bus_t ram,
   inout  wire  [7:0]           ram_data
);

   memctl_pkg::seq_state_e state;
   logic [2:0]             count;
   logic                   start;
   logic                   running;
   logic                   byte_sel;
   logic                   we_b;
   logic [7:0]             low_byte;

   // ------------------------------
   // Access control
   // ------------------------------

   // A selected request the cache cannot serve starts an access from idle
   assign start = req.sel && !hit && (state == memctl_pkg::SEQ_IDLE);

   // Once started the access runs to its last count whatever the CPU does
   assign running = start || (state != memctl_pkg::SEQ_IDLE);

   // Top count bit selects the byte, 0 in counts 0 to 3 and 1 in counts 4 to 7
   assign byte_sel = count[2];

   assign access_end = (count == 3'(memctl_pkg::ACCESS_CYCLES - 1));
   // Counts 0 to 6 keep the CPU stalled
   assign busy = !access_end;

   // Count 0 of an access is spent in idle since the start is only seen that cycle
   // The state then names the byte being transferred in counts 1 to 7
   always_ff @(posedge clock) begin
      if (!reset_b) begin
         count <= '0;
         state <= memctl_pkg::SEQ_IDLE;
      end else if (running) begin
         // The count wraps from 7 back to 0 at the end of the access
         count <= count + 3'd1;
         case (state)
            memctl_pkg::SEQ_IDLE: begin
               state <= memctl_pkg::SEQ_LOW_BYTE;
            end
            memctl_pkg::SEQ_LOW_BYTE: begin
               if (count == 3'(memctl_pkg::CYCLES_PER_BYTE - 1)) begin
                  state <= memctl_pkg::SEQ_HIGH_BYTE;
               end
            end
            memctl_pkg::SEQ_HIGH_BYTE: begin
               if (access_end) begin
                  state <= memctl_pkg::SEQ_IDLE;
               end
            end
            default: begin
               state <= memctl_pkg::SEQ_IDLE;
            end
         endcase
      end
   end

   // ------------------------------
   // Write strobe
   // ------------------------------

   // The strobe comes from a flop so it cannot glitch
   // It is set on the edges that end the first two counts of each byte,
   // so it is low in counts 1, 2, 5 and 6 and the first count gives address setup
   always_ff @(posedge clock) begin
      if (!reset_b) begin
         we_b <= 1'b1;
      end else begin
         we_b <= !(running && !req.rnw && !count[1]);
      end
   end

   // ------------------------------
   // Read data
   // ------------------------------

   // Low byte is captured at the end of its byte cycle
   always_ff @(posedge clock) begin
      if (count == 3'(memctl_pkg::CYCLES_PER_BYTE - 1)) begin
         low_byte <= ram_data;
      end
   end

   // High byte comes straight off the pins and is sampled by the CPU in count 7
   assign rdata = {ram_data, low_byte};

   // ------------------------------
   // SRAM pins
   // ------------------------------

   // Data pins are only driven for a write, the byte following the address bit
   assign ram_data = (req.sel && !req.rnw) ?
                     (byte_sel ? req.wdata[15:8] : req.wdata[7:0]) : 8'bz;

   // The two top address bits are unused and tied low
   always_comb begin
      ram.cs_b = !req.sel;
      ram.oe_b = !req.rnw;
      ram.we_b = we_b;
      ram.addr = {2'b00, req.addr, byte_sel};
   end

   // A strobe left over from a write must never corrupt memory during a read
   a_no_we_on_read: assert property (@(posedge clock) disable iff (!reset_b)
      req.rnw |-> ram.we_b)
      else $error("SRAM write strobe low during a read");

   // The CPU stall length depends on the access ending exactly here
   a_access_length: assert property (@(posedge clock) disable iff (!reset_b)
      start |-> ##7 access_end)
      else $error("access did not end seven cycles after its start");

   // The byte phase and the SRAM address bit have to agree
   a_high_byte_phase: assert property (@(posedge clock) disable iff (!reset_b)
      ram.addr[0] |-> (state == memctl_pkg::SEQ_HIGH_BYTE))
      else $error("odd SRAM address outside the high byte phase");

endmodule

`default_nettype wire

//--- src/cpu_bus_port.sv
/* CPU bus port
   Bundles the CPU pins into a request, stalls the CPU on a miss
   and picks the word returned to the CPU */

`timescale 1ns/1ps
`default_nettype none

module cpu_bus_port (
   input  wire                  ext_cs_b,
   input  wire                  vpa,
   input  wire                  cpu_rnw,
   input  wire  [15:0]          cpu_addr,
   input  wire  [15:0]          cpu_dout,
   input  wire                  hit,
   input  wire  [15:0]          hit_data,
   input  wire                  busy,
   input  wire  [15:0]          rdata,
   output memctl_pkg::cpu_req_t req,
   output logic                 cpu_clken,
   output logic [15:0]          ext_dout
);

   // ------------------------------
   // Request
   // ------------------------------

   // The decoder gives an active low select and the rest of the design wants it high
   always_comb begin
      req.sel   = !ext_cs_b;
      req.vpa   = vpa;
      req.rnw   = cpu_rnw;
      req.addr  = cpu_addr;
      req.wdata = cpu_dout;
   end

   // ------------------------------
   // Stall and read data
   // ------------------------------

   // The CPU is held while a selected request misses the cache
   // Busy covers counts 0 to 6 so the CPU is released in count 7 of the access
   // A hit never stalls because it is served in the same cycle
   assign cpu_clken = !(req.sel && !hit && busy);

   // Cached word on a hit, otherwise the word assembled from the two SRAM bytes
   // The SRAM word is only meaningful in count 7 when the CPU samples it
   assign ext_dout = hit ? hit_data : rdata;

endmodule

`default_nettype wire

//--- src/instr_cache.sv
/* Instruction cache
   64-entry direct-mapped cache for instruction fetches, filled from the SRAM
   and kept coherent by updating a held line on a CPU write */

`timescale 1ns/1ps
`default_nettype none

module instr_cache (
   input  wire                  clock,
   input  wire                  reset_b,
   input  wire memctl_pkg::cpu_req_t req,
   input  wire                  access_end,
   input  wire  [15:0]          rdata,
   output logic                 hit,
   output logic [15:0]          hit_data,
   output logic                 tag_match
);

   // Kept as a small array of flops so the lookup is combinational
   memctl_pkg::cache_line_t lines [memctl_pkg::CACHE_LINES];

   logic [memctl_pkg::CACHE_INDEX_BITS-1:0] index;
   logic [memctl_pkg::CACHE_TAG_BITS-1:0]   tag;
   memctl_pkg::cache_line_t                 entry;
   logic                                    fill;
   logic                                    update;

   // ------------------------------
   // Lookup
   // ------------------------------

   // Low address bits pick the line and the upper bits are compared against its tag
   assign index = req.addr[memctl_pkg::CACHE_INDEX_BITS-1:0];
   assign tag   = req.addr[15 -: memctl_pkg::CACHE_TAG_BITS];
   assign entry = lines[index];

   // Tag match ignores the access type since a write also needs it
   assign tag_match = entry.valid && (entry.tag == tag);

   // Only instruction fetches are served from the cache
   // Data reads always go to the SRAM and writes never hit
   assign hit      = req.vpa && req.rnw && tag_match;
   assign hit_data = entry.data;

   // ------------------------------
   // Fill and update
   // ------------------------------

   // An external instruction fetch leaves its word in the cache when it ends
   assign fill = access_end && req.sel && req.rnw && req.vpa;

   // A write to a held address rewrites the line so later fetches see the new code
   assign update = access_end && req.sel && !req.rnw && tag_match;

   // Both happen on the edge that ends count 7, while the CPU still holds
   // its address and write data
   always_ff @(posedge clock) begin
      if (!reset_b) begin
         for (int i = 0; i < memctl_pkg::CACHE_LINES; i++) begin
            lines[i].valid <= 1'b0;
         end
      end else if (fill) begin
         lines[index] <= '{tag: tag, valid: 1'b1, data: rdata};
      end else if (update) begin
         lines[index] <= '{tag: tag, valid: 1'b1, data: req.wdata};
      end
   end

endmodule

`default_nettype wire

//--- src/memctl_pkg.sv
/* Memory controller package
   Geometry constants and the shared types of the external memory controller */

`default_nettype none

package memctl_pkg;

   // ------------------------------
   // Geometry
   // ------------------------------

   // The cache index comes from address bits 5 to 0
   localparam int CACHE_INDEX_BITS = 6;
   // The tag is the rest of the word address, bits 15 to 6
   localparam int CACHE_TAG_BITS = 10;
   localparam int CACHE_LINES = 64;

   // Each byte on the SRAM gets four clocks, so one 16-bit access takes eight
   localparam int CYCLES_PER_BYTE = 4;
   localparam int ACCESS_CYCLES = 8;

   // ------------------------------
   // Types
   // ------------------------------

   // One CPU bus request, with sel already turned active high
   typedef struct packed {
      logic        sel;
      logic        vpa;
      logic        rnw;
      logic [15:0] addr;
      logic [15:0] wdata;
   } cpu_req_t;

   // One instruction cache entry
   typedef struct packed {
      logic [CACHE_TAG_BITS-1:0] tag;
      logic                      valid;
      logic [15:0]               data;
   } cache_line_t;

   // SRAM control strobes and address, all strobes active low
   typedef struct packed {
      logic        cs_b;
      logic        oe_b;
      logic        we_b;
      logic [18:0] addr;
   } ram_bus_t;

   // Byte phase of the external access
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_LOW_BYTE,
      SEQ_HIGH_BYTE
   } seq_state_e;

endpackage

`default_nettype wire

//--- src/memory_controller.sv
/* External memory controller
   Joins the CPU bus port, the instruction cache and the byte SRAM sequencer */

`timescale 1ns/1ps
`default_nettype none

module memory_controller (
   input  wire         clock,
   input  wire         reset_b,
   // CPU side
   input  wire         ext_cs_b,
   input  wire         vpa,
   input  wire         cpu_rnw,
   input  wire  [15:0] cpu_addr,
   input  wire  [15:0] cpu_dout,
   output logic        cpu_clken,
   output logic [15:0] ext_dout,
   // SRAM side
   output logic        ram_cs_b,
   output logic        ram_oe_b,
   output logic        ram_we_b,
   output logic [18:0] ram_addr,
   inout  wire  [7:0]  ram_data
);

   memctl_pkg::cpu_req_t req;
   memctl_pkg::ram_bus_t ram;
   logic                 hit;
   logic [15:0]          hit_data;
   logic                 busy;
   logic                 access_end;
   logic [15:0]          rdata;

   cpu_bus_port port_i (
      .ext_cs_b  (ext_cs_b),
      .vpa       (vpa),
      .cpu_rnw   (cpu_rnw),
      .cpu_addr  (cpu_addr),
      .cpu_dout  (cpu_dout),
      .hit       (hit),
      .hit_data  (hit_data),
      .busy      (busy),
      .rdata     (rdata),
      .req       (req),
      .cpu_clken (cpu_clken),
      .ext_dout  (ext_dout)
   );

   instr_cache cache_i (
      .clock      (clock),
      .reset_b    (reset_b),
      .req        (req),
      .access_end (access_end),
      .rdata      (rdata),
      .hit        (hit),
      .hit_data   (hit_data),
      .tag_match  ()
   );

   byte_sram_sequencer seq_i (
      .clock      (clock),
      .reset_b    (reset_b),
      .req        (req),
      .hit        (hit),
      .busy       (busy),
      .access_end (access_end),
      .rdata      (rdata),
      .ram        (ram),
      .ram_data   (ram_data)
   );

   // SRAM bus struct out to the pins
   assign ram_cs_b = ram.cs_b;
   assign ram_oe_b = ram.oe_b;
   assign ram_we_b = ram.we_b;
   assign ram_addr = ram.addr;

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
/* Clock and reset generator
   8 ns clock, reset held low for the first five cycles */

`timescale 1ns/1ps
`default_nettype none

module clock_gen (
   output logic clock,
   output logic reset_b
);

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   // Released on a falling edge so the first active edge sees a clean level
   initial begin
      reset_b = 1'b0;
      repeat (5) @(posedge clock);
      @(negedge clock);
      reset_b = 1'b1;
   end

endmodule

`default_nettype wire

//--- testbench/memory_controller_tb.sv
/* Memory controller testbench
   Runs directed and random CPU accesses against a reference memory and tag model
   and checks stall length, read data, SRAM pins and SRAM contents */

`timescale 1ns/1ps
`default_nettype none

module memory_controller_tb;

   logic        clock;
   logic        reset_b;
   logic        ext_cs_b;
   logic        vpa;
   logic        cpu_rnw;
   logic [15:0] cpu_addr;
   logic [15:0] cpu_dout;
   logic        cpu_clken;
   logic [15:0] ext_dout;
   logic        ram_cs_b;
   logic        ram_oe_b;
   logic        ram_we_b;
   logic [18:0] ram_addr;
   wire  [7:0]  ram_data;

   // Reference memory and a tag-only cache model, data always comes from memory
   logic [7:0]  ref_mem [2**17];
   logic [9:0]  ref_tag [64];
   logic        ref_valid [64];
   logic [31:0] lcg_state;

   // Expectations for the access in flight, all set on the falling edge
   string       test_name;
   logic        active;
   logic        exp_miss;
   logic [15:0] exp_dout;
   logic        check_mem;
   logic [15:0] exp_word;
   logic [15:0] mem_word;
   int          stall_cnt;
   logic        released;
   int          cycle_count;
   int          accesses = 0;

   int idle_errors = 0;
   int stall_errors = 0;
   int data_errors = 0;
   int strobe_errors = 0;
   int addr_errors = 0;
   int mem_errors = 0;
   int ctrl_errors = 0;

   clock_gen clock_i (
      .clock   (clock),
      .reset_b (reset_b)
   );

   memory_controller dut_i (
      .clock     (clock),
      .reset_b   (reset_b),
      .ext_cs_b  (ext_cs_b),
      .vpa       (vpa),
      .cpu_rnw   (cpu_rnw),
      .cpu_addr  (cpu_addr),
      .cpu_dout  (cpu_dout),
      .cpu_clken (cpu_clken),
      .ext_dout  (ext_dout),
      .ram_cs_b  (ram_cs_b),
      .ram_oe_b  (ram_oe_b),
      .ram_we_b  (ram_we_b),
      .ram_addr  (ram_addr),
      .ram_data  (ram_data)
   );

   sram_model sram_i (
      .cs_b (ram_cs_b),
      .oe_b (ram_oe_b),
      .we_b (ram_we_b),
      .addr (ram_addr),
      .data (ram_data)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // Write strobe is low in the second, third, sixth and seventh cycle
   function automatic logic expected_we_b(input int cycle);
      return !(cycle == 1 || cycle == 2 || cycle == 5 || cycle == 6);
   endfunction

   // Low byte in the first four cycles, high byte in the last four
   function automatic logic [18:0] expected_ram_addr(input logic [15:0] addr, input int cycle);
      return {2'b00, addr, cycle >= 4};
   endfunction

   // ------------------------------
   // Cycle tracking
   // ------------------------------

   // Stall count equals the access cycle number, 0 to 7
   // Released marks the edge where the CPU moved on
   always @(posedge clock) begin
      if (!active) begin
         stall_cnt <= 0;
      end else if (!cpu_clken) begin
         stall_cnt <= stall_cnt + 1;
      end
      released <= active && cpu_clken;
   end

   // Limit of 60 accesses at 10 cycles each
   always @(posedge clock) begin
      if (!reset_b) begin
         cycle_count <= 0;
      end else begin
         cycle_count <= cycle_count + 1;
         if (cycle_count >= 60 * 10) begin
            $display("Timeout: the accesses did not finish within %0d cycles", 60 * 10);
            $display("Done: errors found");
            $finish;
         end
      end
   end

   // ------------------------------
   // Checks
   // ------------------------------

   a_idle: assert property (@(posedge clock) disable iff (!reset_b)
      ext_cs_b |-> (cpu_clken && ram_we_b))
      else begin
         idle_errors++;
         $display("Idle check: CPU stalled or SRAM write strobe low without chip select");
      end

   a_stall: assert property (@(posedge clock) disable iff (!reset_b)
      (active && cpu_clken) |-> (stall_cnt == (exp_miss ? 7 : 0)))
      else begin
         stall_errors++;
         $display("FAIL %s stall cycles expected %0d actual %0d",
                  test_name, exp_miss ? 7 : 0, $sampled(stall_cnt));
      end

   a_data: assert property (@(posedge clock) disable iff (!reset_b)
      (active && cpu_rnw && cpu_clken) |-> (ext_dout == exp_dout))
      else begin
         data_errors++;
         $display("FAIL %s read data expected %h actual %h",
                  test_name, exp_dout, $sampled(ext_dout));
      end

   a_strobe: assert property (@(posedge clock) disable iff (!reset_b)
      (active && !cpu_rnw) |-> (ram_we_b == expected_we_b(stall_cnt)))
      else begin
         strobe_errors++;
         $display("FAIL %s ram_we_b in cycle %0d expected %b actual %b", test_name,
                  $sampled(stall_cnt), expected_we_b($sampled(stall_cnt)), $sampled(ram_we_b));
      end

   a_addr: assert property (@(posedge clock) disable iff (!reset_b)
      active |-> (ram_addr == expected_ram_addr(cpu_addr, stall_cnt)))
      else begin
         addr_errors++;
         $display("FAIL %s ram_addr expected %h actual %h", test_name,
                  expected_ram_addr(cpu_addr, $sampled(stall_cnt)), $sampled(ram_addr));
      end

   // SRAM select follows the CPU select and the output enable follows the read flag
   a_ctrl: assert property (@(posedge clock) disable iff (!reset_b)
      (ram_cs_b == ext_cs_b) && (ram_oe_b == !cpu_rnw))
      else begin
         ctrl_errors++;
         $display("FAIL %s ram_cs_b ram_oe_b expected %b %b actual %b %b", test_name,
                  $sampled(ext_cs_b), !$sampled(cpu_rnw), $sampled(ram_cs_b),
                  $sampled(ram_oe_b));
      end

   a_mem: assert property (@(posedge clock) disable iff (!reset_b)
      check_mem |-> (mem_word == exp_word))
      else begin
         mem_errors++;
         $display("FAIL %s SRAM word expected %h actual %h", test_name, exp_word, mem_word);
      end

   // ------------------------------
   // Stimulus
   // ------------------------------

   // Starts on a falling edge and ends on the falling edge after one idle cycle
   task automatic run_access(input string name, input logic fetch, input logic rnw,
                             input logic [15:0] addr, input logic [15:0] wdata);
      logic [5:0]  index;
      logic [9:0]  tag;
      logic [16:0] even;
      logic [16:0] odd;
      logic        hit_expected;
      index = addr[5:0];
      tag = addr[15:6];
      even = {addr, 1'b0};
      odd = {addr, 1'b1};
      hit_expected = fetch && rnw && ref_valid[index] && (ref_tag[index] == tag);
      test_name = name;
      exp_miss = !hit_expected;
      exp_dout = {ref_mem[odd], ref_mem[even]};
      ext_cs_b = 1'b0;
      vpa = fetch;
      cpu_rnw = rnw;
      cpu_addr = addr;
      cpu_dout = wdata;
      active = 1'b1;
      do @(negedge clock); while (!released);
      // A write updates memory and leaves a held line valid with its new word
      if (!rnw) begin
         ref_mem[even] = wdata[7:0];
         ref_mem[odd] = wdata[15:8];
      end else if (fetch && !hit_expected) begin
         ref_valid[index] = 1'b1;
         ref_tag[index] = tag;
      end
      active = 1'b0;
      ext_cs_b = 1'b1;
      vpa = 1'b0;
      cpu_rnw = 1'b1;
      if (!rnw) begin
         exp_word = wdata;
         mem_word = {sram_i.peek(odd), sram_i.peek(even)};
         check_mem = 1'b1;
      end
      accesses++;
      @(negedge clock);
      check_mem = 1'b0;
   endtask

   initial begin
      logic [31:0] r;
      logic [15:0] addr;
      logic [15:0] wdata;
      int          total;
      ext_cs_b = 1'b1;
      vpa = 1'b0;
      cpu_rnw = 1'b1;
      cpu_addr = '0;
      cpu_dout = '0;
      active = 1'b0;
      check_mem = 1'b0;
      exp_miss = 1'b0;
      exp_dout = '0;
      exp_word = '0;
      mem_word = '0;
      test_name = "reset";
      // Same generator output goes into the SRAM and the reference copy
      lcg_state = 32'd20;
      for (int i = 0; i < 2**17; i++) begin
         lcg_state = lcg_next(lcg_state);
         ref_mem[i] = lcg_state[23:16];
         sram_i.poke(17'(i), lcg_state[23:16]);
      end
      for (int i = 0; i < 64; i++) begin
         ref_valid[i] = 1'b0;
         ref_tag[i] = '0;
      end
      @(posedge reset_b);
      repeat (2) @(negedge clock);

      run_access("miss_read", 1'b0, 1'b1, 16'h0123, 16'h0000);
      run_access("fetch_miss", 1'b1, 1'b1, 16'h0010, 16'h0000);
      run_access("fetch_hit", 1'b1, 1'b1, 16'h0010, 16'h0000);
      run_access("data_read_cached", 1'b0, 1'b1, 16'h0010, 16'h0000);
      run_access("write", 1'b0, 1'b0, 16'h0200, 16'ha55a);
      run_access("write_readback", 1'b0, 1'b1, 16'h0200, 16'h0000);
      // Index 0x10 with tag 0x11 conflicts with address 0x0010
      run_access("write_cached", 1'b0, 1'b0, 16'h0010, 16'h1234);
      run_access("fetch_after_write", 1'b1, 1'b1, 16'h0010, 16'h0000);
      run_access("fetch_conflict", 1'b1, 1'b1, 16'h0450, 16'h0000);
      run_access("fetch_replaced", 1'b1, 1'b1, 16'h0450, 16'h0000);
      run_access("fetch_evicted", 1'b1, 1'b1, 16'h0010, 16'h0000);

      // Eight indexes times four tags gives plenty of hits and conflicts
      for (int n = 0; n < 40; n++) begin
         lcg_state = lcg_next(lcg_state);
         r = lcg_state;
         lcg_state = lcg_next(lcg_state);
         wdata = lcg_state[31:16];
         addr = {8'h00, r[17:16], 3'b000, r[20:18]};
         case (r[23:22])
            2'd2: run_access("random_data_read", 1'b0, 1'b1, addr, wdata);
            2'd3: run_access("random_write", 1'b0, 1'b0, addr, wdata);
            default: run_access("random_fetch", 1'b1, 1'b1, addr, wdata);
         endcase
      end

      repeat (2) @(negedge clock);
      total = idle_errors + stall_errors + data_errors + strobe_errors + addr_errors
              + mem_errors + ctrl_errors;
      $display(
         "Accesses %0d, errors idle %0d stall %0d data %0d strobe %0d addr %0d mem %0d ctrl %0d",
         accesses, idle_errors, stall_errors, data_errors, strobe_errors, addr_errors,
         mem_errors, ctrl_errors);
      if (total == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/sram_model.sv
/* Behavioral byte-wide SRAM
   Asynchronous read onto a tristate bus, write on the rising write strobe,
   with backdoor access for preload and checking */

`timescale 1ns/1ps
`default_nettype none

module sram_model (
   input  wire        cs_b,
   input  wire        oe_b,
   input  wire        we_b,
   input  wire [18:0] addr,
   inout  wire [7:0]  data
);

   // Only the low 17 address bits are wired on the board
   logic [7:0] mem [2**17];

   // The part drives its pins only when selected, enabled and not being written
   assign data = (!cs_b && !oe_b && we_b) ? mem[addr[16:0]] : 8'bz;

   // Like a real asynchronous SRAM the byte is taken at the end of the strobe
   always @(posedge we_b) begin
      if (!cs_b) begin
         mem[addr[16:0]] = data;
      end
   end

   // ------------------------------
   // Backdoor
   // ------------------------------

   function automatic logic [7:0] peek(input logic [16:0] byte_addr);
      return mem[byte_addr];
   endfunction

   task automatic poke(input logic [16:0] byte_addr, input logic [7:0] value);
      mem[byte_addr] = value;
   endtask

endmodule

`default_nettype wire
